// File: dv/tb_mem_model.sv
/*
 * memory model for the core testbench
 * word memory acting as four-phase slave, each ack edge delayed
 * by 0 to 3 cycles from an lcg
 */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model (
  input  wire logic        CLK,
  input  wire logic        nRST,
  input  wire logic        req,
  input  wire logic        we,
  input  wire logic [31:0] addr,
  input  wire logic [31:0] wdata,
  output logic [31:0]      rdata,
  output logic             ack
);

  localparam int DEPTH = 256;

  logic [31:0] mem [DEPTH];
  logic [31:0] lcg_state;
  logic [31:0] fill_addr;

  // numerical recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // program and data words from the test top
  task preload(input int idx, input logic [31:0] data);
    mem[idx] = data;
  endtask

  initial begin
    ack       = 1'b0;
    rdata     = '0;
    lcg_state = 32'hef0c_0f21;
    // unwritten words differ per byte address
    for (int i = 0; i < DEPTH; i++) begin
      fill_addr = i * 4;
      mem[i]    = {~fill_addr[15:0], fill_addr[15:0]};
    end
  end

  // one transfer per pass
  always begin
    @(posedge CLK);
    if (nRST && req && !ack) begin
      lcg_state = lcg_next(lcg_state);
      // top bits spread best
      repeat (lcg_state[31:30]) @(posedge CLK);
      #2;
      if (we)
        mem[addr[9:2]] = wdata;
      else
        rdata = mem[addr[9:2]];
      ack = 1'b1;
      // master drops req
      @(posedge CLK);
      while (req)
        @(posedge CLK);
      lcg_state = lcg_next(lcg_state);
      repeat (lcg_state[31:30]) @(posedge CLK);
      #2 ack = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_rv_core.sv
/*
 * core testbench
 * runs a small program through rv_core against the memory model,
 * checks every bus store, the four-phase rules and halt
 */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_ROWS       = 24;
  localparam int CYCLES_PER_ROW = 400;
  localparam int QUIET_CYCLES   = 30;

  logic        CLK;
  logic        nRST;
  logic        bus_req, bus_we, bus_ack, halt;
  logic [31:0] bus_addr, bus_wdata, bus_rdata;

  // program table, store rows carry the expected bus write
  logic [31:0] prog_word [NUM_ROWS];
  logic        row_is_store [NUM_ROWS];
  logic [31:0] row_addr [NUM_ROWS];
  logic [31:0] row_data [NUM_ROWS];
  int          row_count;
  int          store_rows [$];
  int          store_pos;
  int          row_sel;
  int          error_count;

  // bus history from the previous samples
  logic        req_q = 1'b0;
  logic        ack_q = 1'b0;
  logic        we_q = 1'b0;
  logic        halt_q = 1'b0;
  logic [31:0] addr_q = '0;
  logic [31:0] wdata_q = '0;
  logic        first_req = 1'b1;
  logic        req_rise;

  rv_core u_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .bus_req   (bus_req),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .halt      (halt)
  );

  tb_mem_model u_mem (
    .CLK   (CLK),
    .nRST  (nRST),
    .req   (bus_req),
    .we    (bus_we),
    .addr  (bus_addr),
    .wdata (bus_wdata),
    .rdata (bus_rdata),
    .ack   (bus_ack)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  task automatic stop_on_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
    error_count++;
    $display("[FAIL] %0t ns %s: got 32'h%08h, expected 32'h%08h", $time, name, got, exp);
    $display("Done: errors found");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic stop_on_error(input string what);
    error_count++;
    $display("error at %0t ns: %s", $time, what);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  // rv32i encoders
  function automatic logic [31:0] enc_addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] enc_sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  task add_row(input logic [31:0] word, input logic is_st, input logic [31:0] addr,
               input logic [31:0] data);
    prog_word[row_count]    = word;
    row_is_store[row_count] = is_st;
    row_addr[row_count]     = addr;
    row_data[row_count]     = data;
    row_count++;
  endtask

  // register values in the comments are the ISA results by hand
  task build_program;
    row_count = 0;
    add_row(enc_addi(5'd1, 5'd0, 12'd5), 1'b0, '0, '0);                  // x1 = 5
    add_row(enc_addi(5'd2, 5'd1, 12'hffd), 1'b0, '0, '0);                // x2 = 2
    add_row(enc_lui(5'd3, 20'h12345), 1'b0, '0, '0);                     // x3 = 1234_5000
    add_row(enc_r(7'h00, 3'b000, 5'd4, 5'd3, 5'd2), 1'b0, '0, '0);       // add x4 = 1234_5002
    add_row(enc_r(7'h20, 3'b000, 5'd5, 5'd4, 5'd1), 1'b0, '0, '0);       // sub x5 = 1234_4ffd
    add_row(enc_sw(5'd5, 5'd0, 12'h200), 1'b1, 32'h200, 32'h1234_4ffd);
    add_row(enc_r(7'h00, 3'b111, 5'd6, 5'd4, 5'd5), 1'b0, '0, '0);       // and x6 = 1234_4000
    add_row(enc_r(7'h00, 3'b110, 5'd7, 5'd1, 5'd2), 1'b0, '0, '0);       // or x7 = 7
    add_row(enc_r(7'h00, 3'b100, 5'd8, 5'd4, 5'd5), 1'b0, '0, '0);       // xor x8 = 1fff
    add_row(enc_sw(5'd6, 5'd0, 12'h204), 1'b1, 32'h204, 32'h1234_4000);
    add_row(enc_sw(5'd7, 5'd0, 12'h208), 1'b1, 32'h208, 32'h0000_0007);
    add_row(enc_sw(5'd8, 5'd0, 12'h20c), 1'b1, 32'h20c, 32'h0000_1fff);
    // load back the first store, then independent work behind it
    add_row(enc_lw(5'd9, 5'd0, 12'h200), 1'b0, '0, '0);                  // x9 = 1234_4ffd
    add_row(enc_addi(5'd10, 5'd0, 12'h100), 1'b0, '0, '0);               // x10 = 100
    add_row(enc_r(7'h00, 3'b100, 5'd11, 5'd10, 5'd7), 1'b0, '0, '0);     // xor x11 = 107
    add_row(enc_r(7'h00, 3'b000, 5'd12, 5'd9, 5'd1), 1'b0, '0, '0);      // add x12 = 1234_5002
    add_row(enc_r(7'h20, 3'b000, 5'd13, 5'd12, 5'd10), 1'b0, '0, '0);    // sub x13 = 1234_4f02
    add_row(enc_sw(5'd11, 5'd0, 12'h210), 1'b1, 32'h210, 32'h0000_0107);
    add_row(enc_sw(5'd13, 5'd0, 12'h214), 1'b1, 32'h214, 32'h1234_4f02);
    add_row(enc_addi(5'd14, 5'd0, 12'hfff), 1'b0, '0, '0);               // x14 = ffff_ffff
    add_row(enc_sw(5'd14, 5'd0, 12'h218), 1'b1, 32'h218, 32'hffff_ffff);
    // write to x0 is dropped
    add_row(enc_addi(5'd0, 5'd1, 12'd7), 1'b0, '0, '0);
    add_row(enc_sw(5'd0, 5'd0, 12'h21c), 1'b1, 32'h21c, 32'h0000_0000);
    add_row(32'h0000_0073, 1'b0, '0, '0);                                // ecall
  endtask

  assign req_rise = bus_req && !req_q;

  // bus monitor, sampled at the rising edge
  always @(posedge CLK) begin
    if (nRST) begin
      assert (!(req_q && !ack_q) || bus_req)
        else stop_on_error("bus_req fell before bus_ack was seen");
      if (req_q && bus_req) begin
        assert (bus_addr == addr_q) else stop_on_mismatch("bus_addr", bus_addr, addr_q);
        assert (bus_wdata == wdata_q) else stop_on_mismatch("bus_wdata", bus_wdata, wdata_q);
        assert (bus_we == we_q) else stop_on_mismatch("bus_we", bus_we, we_q);
      end
      if (req_rise) begin
        assert (!bus_ack) else stop_on_error("bus_req rose while bus_ack was still high");
        // halt already up before the edge that raised req
        assert (!halt_q) else stop_on_error("a bus request started after halt");
        if (first_req) begin
          assert (bus_addr == rv_core_pkg::RESET_PC)
            else stop_on_mismatch("bus_addr", bus_addr, rv_core_pkg::RESET_PC);
          assert (!bus_we) else stop_on_mismatch("bus_we", bus_we, 32'd0);
          first_req = 1'b0;
        end
        if (bus_we) begin
          if (store_pos >= store_rows.size()) begin
            stop_on_error("store on the bus beyond the expected stores");
          end else begin
            row_sel = store_rows[store_pos];
            assert (bus_addr == row_addr[row_sel])
              else stop_on_mismatch("bus_addr", bus_addr, row_addr[row_sel]);
            assert (bus_wdata == row_data[row_sel])
              else stop_on_mismatch("bus_wdata", bus_wdata, row_data[row_sel]);
            store_pos++;
          end
        end
      end
      assert (!halt_q || halt) else stop_on_error("halt fell before reset");
      // every earlier store must be out before halt
      if (halt && !halt_q)
        assert (store_pos == store_rows.size())
          else stop_on_mismatch("stores before halt", store_pos, store_rows.size());
    end
    req_q   <= bus_req;
    ack_q   <= bus_ack;
    we_q    <= bus_we;
    addr_q  <= bus_addr;
    wdata_q <= bus_wdata;
    halt_q  <= halt;
  end

  // watchdog
  initial begin
    #(NUM_ROWS * CYCLES_PER_ROW * CLK_PERIOD);
    $display("timeout: halt not reached within %0d cycles", NUM_ROWS * CYCLES_PER_ROW);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    nRST        = 1'b0;
    error_count = 0;
    store_pos   = 0;
    build_program();
    if (row_count != NUM_ROWS)
      stop_on_error("program table length differs from NUM_ROWS");
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (row_is_store[i])
        store_rows.push_back(i);
    end
    // model fills itself at time zero, program goes in after
    @(posedge CLK);
    for (int i = 0; i < NUM_ROWS; i++)
      u_mem.preload((rv_core_pkg::RESET_PC >> 2) + i, prog_word[i]);
    repeat (RESET_CYCLES - 1) @(posedge CLK);
    #2 nRST = 1'b1;
    @(posedge CLK);
    assert (!bus_req) else stop_on_mismatch("bus_req", bus_req, 32'd0);
    assert (!halt) else stop_on_mismatch("halt", halt, 32'd0);
    wait (halt);
    // bus must stay quiet after halt
    repeat (QUIET_CYCLES) @(posedge CLK);
    if (error_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/rv_core_pkg.sv
src/fetch_unit.sv
src/decode_execute.sv
src/completion_buffer.sv
src/reg_file.sv
src/hazard_unit.sv
src/mem_arbiter.sv
src/rv_core.sv
dv/tb_mem_model.sv
dv/tb_rv_core.sv

// File: src/completion_buffer.sv
/*
 * completion buffer
 * circular queue filled in program order, completed in any order,
 * retired from the head into the register file
 */
`timescale 1ns/100ps
`default_nettype none

module completion_buffer (
  input  wire logic                               CLK,
  input  wire logic                               nRST,
  input  wire logic                               alloc,
  input  wire logic [rv_core_pkg::REG_ADDR_W-1:0] alloc_rd,
  input  wire logic                               alloc_has_rd,
  input  wire logic                               alloc_halt,
  output logic [rv_core_pkg::CB_IDX_W-1:0]        alloc_idx,
  output logic                                    cb_full,
  output logic [(1<<rv_core_pkg::REG_ADDR_W)-1:0] busy_regs,
  input  wire logic                               complete,
  input  wire logic [rv_core_pkg::CB_IDX_W-1:0]   cmp_idx,
  input  wire logic [rv_core_pkg::XLEN-1:0]       cmp_data,
  output logic                                    wr_en,
  output logic [rv_core_pkg::REG_ADDR_W-1:0]      wr_addr,
  output logic [rv_core_pkg::XLEN-1:0]            wr_data,
  output logic                                    head_is_halt
);

  logic [rv_core_pkg::CB_DEPTH-1:0]   valid_q, done_q, halt_q, has_rd_q;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rd_q   [rv_core_pkg::CB_DEPTH];
  logic [rv_core_pkg::XLEN-1:0]       data_q [rv_core_pkg::CB_DEPTH];
  logic [rv_core_pkg::CB_IDX_W-1:0]   head, tail;
  logic [rv_core_pkg::CB_IDX_W:0]     count;
  logic                               retire;

  assign alloc_idx = tail;
  assign cb_full   = (count == rv_core_pkg::CB_DEPTH);

  // head leaves once its result is in
  assign retire       = valid_q[head] && done_q[head];
  assign wr_en        = retire && has_rd_q[head];
  assign wr_addr      = rd_q[head];
  assign wr_data      = data_q[head];
  assign head_is_halt = retire && halt_q[head];

  // pending mask over all live entries, so a repeated rd stays busy
  always_comb begin
    busy_regs = '0;
    for (int i = 0; i < rv_core_pkg::CB_DEPTH; i++) begin
      if (valid_q[i] && has_rd_q[i])
        busy_regs[rd_q[i]] = 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
      done_q  <= '0;
      head    <= '0;
      tail    <= '0;
      count   <= '0;
    end else begin
      if (complete)
        done_q[cmp_idx] <= 1'b1;
      if (retire) begin
        valid_q[head] <= 1'b0;
        head          <= head + 1'b1;
      end
      // ecall is finished as soon as it is allocated
      if (alloc) begin
        valid_q[tail] <= 1'b1;
        done_q[tail]  <= alloc_halt;
        tail          <= tail + 1'b1;
      end
      count <= count + (alloc ? 1'b1 : 1'b0) - (retire ? 1'b1 : 1'b0);
    end
  end

  always_ff @(posedge CLK) begin
    if (alloc) begin
      rd_q[tail]     <= alloc_rd;
      has_rd_q[tail] <= alloc_has_rd;
      halt_q[tail]   <= alloc_halt;
    end
    if (complete)
      data_q[cmp_idx] <= cmp_data;
  end

  // execute only completes entries it allocated and has not finished
  a_cmp_live : assert property (@(posedge CLK) disable iff (!nRST)
    complete |-> valid_q[cmp_idx] && !done_q[cmp_idx]);

endmodule

`default_nettype wire

// File: src/decode_execute.sv
/*
 * decode and execute stage
 * decodes the fetched word, computes alu results and addresses,
 * runs the data port master and reports completions to the buffer
 */
`timescale 1ns/100ps
`default_nettype none

module decode_execute (
  input  wire logic                               CLK,
  input  wire logic                               nRST,
  input  wire logic                               fd_valid,
  input  wire logic [rv_core_pkg::XLEN-1:0]       fd_instr,
  input  wire logic                               issue,
  output rv_core_pkg::opcode_t                    dec_op,
  output logic [rv_core_pkg::REG_ADDR_W-1:0]      rs1,
  output logic [rv_core_pkg::REG_ADDR_W-1:0]      rs2,
  input  wire logic [rv_core_pkg::XLEN-1:0]       rd1,
  input  wire logic [rv_core_pkg::XLEN-1:0]       rd2,
  output logic                                    alloc,
  output logic [rv_core_pkg::REG_ADDR_W-1:0]      alloc_rd,
  output logic                                    alloc_has_rd,
  output logic                                    alloc_halt,
  input  wire logic [rv_core_pkg::CB_IDX_W-1:0]   alloc_idx,
  output logic                                    complete,
  output logic [rv_core_pkg::CB_IDX_W-1:0]        cmp_idx,
  output logic [rv_core_pkg::XLEN-1:0]            cmp_data,
  output logic                                    d_req,
  output logic                                    d_we,
  output logic [rv_core_pkg::XLEN-1:0]            d_addr,
  output logic [rv_core_pkg::XLEN-1:0]            d_wdata,
  input  wire logic                               d_ack,
  input  wire logic [rv_core_pkg::XLEN-1:0]       d_rdata,
  output logic                                    d_busy
);

  logic [6:0]                        opc;
  logic [2:0]                        funct3;
  logic [rv_core_pkg::XLEN-1:0]      imm_i, imm_s, imm_u, alu_res;
  logic                              is_mem;
  rv_core_pkg::bus_state_t           d_state;
  // alu result waiting one cycle, memory result waiting for a free slot
  logic                              alu_vld, mem_pend;
  logic [rv_core_pkg::CB_IDX_W-1:0]  alu_idx, mem_idx;
  logic [rv_core_pkg::XLEN-1:0]      alu_data, mem_data;

  assign opc    = fd_instr[6:0];
  assign funct3 = fd_instr[14:12];
  assign rs1    = fd_instr[19:15];
  assign rs2    = fd_instr[24:20];
  assign imm_i  = {{20{fd_instr[31]}}, fd_instr[31:20]};
  assign imm_s  = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
  assign imm_u  = {fd_instr[31:12], 12'h000};

  always_comb begin
    dec_op = rv_core_pkg::OP_ILLEGAL;
    case (opc)
      7'b0010011: if (funct3 == 3'b000) dec_op = rv_core_pkg::OP_ADDI;
      7'b0110011: begin
        if (fd_instr[31:25] == 7'b0000000) begin
          case (funct3)
            3'b000: dec_op = rv_core_pkg::OP_ADD;
            3'b100: dec_op = rv_core_pkg::OP_XOR;
            3'b110: dec_op = rv_core_pkg::OP_OR;
            3'b111: dec_op = rv_core_pkg::OP_AND;
            default: dec_op = rv_core_pkg::OP_ILLEGAL;
          endcase
        end else if (fd_instr[31:25] == 7'b0100000 && funct3 == 3'b000) begin
          dec_op = rv_core_pkg::OP_SUB;
        end
      end
      7'b0110111: dec_op = rv_core_pkg::OP_LUI;
      7'b0000011: if (funct3 == 3'b010) dec_op = rv_core_pkg::OP_LW;
      7'b0100011: if (funct3 == 3'b010) dec_op = rv_core_pkg::OP_SW;
      // only the plain ecall encoding
      7'b1110011: if (fd_instr == 32'h0000_0073) dec_op = rv_core_pkg::OP_ECALL;
      default: dec_op = rv_core_pkg::OP_ILLEGAL;
    endcase
  end

  always_comb begin
    case (dec_op)
      rv_core_pkg::OP_ADDI: alu_res = rd1 + imm_i;
      rv_core_pkg::OP_ADD:  alu_res = rd1 + rd2;
      rv_core_pkg::OP_SUB:  alu_res = rd1 - rd2;
      rv_core_pkg::OP_AND:  alu_res = rd1 & rd2;
      rv_core_pkg::OP_OR:   alu_res = rd1 | rd2;
      rv_core_pkg::OP_XOR:  alu_res = rd1 ^ rd2;
      rv_core_pkg::OP_LUI:  alu_res = imm_u;
      default:              alu_res = '0;
    endcase
  end

  assign is_mem = (dec_op == rv_core_pkg::OP_LW) || (dec_op == rv_core_pkg::OP_SW);

  // buffer entry reserved in the issue cycle
  assign alloc        = issue;
  assign alloc_rd     = fd_instr[11:7];
  assign alloc_halt   = (dec_op == rv_core_pkg::OP_ECALL);
  assign alloc_has_rd = !(dec_op == rv_core_pkg::OP_SW || alloc_halt) && (alloc_rd != '0);

  // memory completion yields to a same-cycle alu completion
  assign complete = alu_vld || mem_pend;
  assign cmp_idx  = alu_vld ? alu_idx : mem_idx;
  assign cmp_data = alu_vld ? alu_data : mem_data;
  assign d_busy   = (d_state != rv_core_pkg::BUS_IDLE) || mem_pend;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      alu_vld  <= 1'b0;
      mem_pend <= 1'b0;
      d_req    <= 1'b0;
      d_state  <= rv_core_pkg::BUS_IDLE;
    end else begin
      alu_vld <= issue && !is_mem && !alloc_halt;
      if (mem_pend && !alu_vld)
        mem_pend <= 1'b0;
      case (d_state)
        rv_core_pkg::BUS_IDLE: begin
          if (issue && is_mem) begin
            d_req   <= 1'b1;
            d_state <= rv_core_pkg::BUS_REQ;
          end
        end
        rv_core_pkg::BUS_REQ: begin
          if (d_ack) begin
            d_req    <= 1'b0;
            mem_pend <= 1'b1;
            d_state  <= rv_core_pkg::BUS_RELEASE;
          end
        end
        rv_core_pkg::BUS_RELEASE: begin
          if (!d_ack)
            d_state <= rv_core_pkg::BUS_IDLE;
        end
        default: d_state <= rv_core_pkg::BUS_IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge CLK) begin
    alu_idx  <= alloc_idx;
    alu_data <= alu_res;
    if (issue && is_mem) begin
      mem_idx <= alloc_idx;
      d_we    <= (dec_op == rv_core_pkg::OP_SW);
      d_addr  <= rd1 + ((dec_op == rv_core_pkg::OP_SW) ? imm_s : imm_i);
      d_wdata <= rd2;
    end
    if (d_state == rv_core_pkg::BUS_REQ && d_ack)
      mem_data <= d_rdata;
  end

  // hazard control drops unknown words instead of issuing them
  a_no_illegal : assert property (@(posedge CLK) disable iff (!nRST)
    issue |-> fd_valid && dec_op != rv_core_pkg::OP_ILLEGAL);

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
/*
 * fetch unit
 * program counter plus four-phase master on the arbiter fetch port,
 * holds one fetched word until decode takes it
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
  input  wire logic                         CLK,
  input  wire logic                         nRST,
  input  wire logic                         stall,
  input  wire logic                         halt,
  output logic                              if_req,
  output logic [rv_core_pkg::XLEN-1:0]      if_addr,
  input  wire logic                         if_ack,
  input  wire logic [rv_core_pkg::XLEN-1:0] if_rdata,
  output logic                              fd_valid,
  output logic [rv_core_pkg::XLEN-1:0]      fd_instr
);

  rv_core_pkg::bus_state_t state;
  logic                    consume;

  // word leaves this cycle
  assign consume = fd_valid && !stall;

  // pc is the address of the outstanding or next fetch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= rv_core_pkg::BUS_IDLE;
      if_req   <= 1'b0;
      if_addr  <= rv_core_pkg::RESET_PC;
      fd_valid <= 1'b0;
    end else begin
      if (consume)
        fd_valid <= 1'b0;
      case (state)
        rv_core_pkg::BUS_IDLE: begin
          // only one word buffered, slave ack must be low
          if (!halt && !if_ack && (!fd_valid || consume)) begin
            if_req <= 1'b1;
            state  <= rv_core_pkg::BUS_REQ;
          end
        end
        rv_core_pkg::BUS_REQ: begin
          if (if_ack) begin
            if_req   <= 1'b0;
            fd_valid <= 1'b1;
            if_addr  <= if_addr + 32'd4;
            state    <= rv_core_pkg::BUS_RELEASE;
          end
        end
        rv_core_pkg::BUS_RELEASE: begin
          if (!if_ack)
            state <= rv_core_pkg::BUS_IDLE;
        end
        default: state <= rv_core_pkg::BUS_IDLE;
      endcase
    end
  end

  // instruction word is payload
  always_ff @(posedge CLK) begin
    if (state == rv_core_pkg::BUS_REQ && if_ack)
      fd_instr <= if_rdata;
  end

  // request held until the arbiter forwards an ack
  a_req_held : assert property (@(posedge CLK) disable iff (!nRST)
    if_req && !if_ack |=> if_req);

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
/*
 * hazard control
 * decides each cycle whether the fetched word issues, stalls or is
 * dropped, and raises halt once ecall retires
 */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
  input  wire logic                               CLK,
  input  wire logic                               nRST,
  input  wire logic                               fd_valid,
  input  rv_core_pkg::opcode_t                    dec_op,
  input  wire logic [rv_core_pkg::REG_ADDR_W-1:0] rs1,
  input  wire logic [rv_core_pkg::REG_ADDR_W-1:0] rs2,
  input  wire logic [(1<<rv_core_pkg::REG_ADDR_W)-1:0] busy_regs,
  input  wire logic                               cb_full,
  input  wire logic                               d_busy,
  input  wire logic                               head_is_halt,
  output logic                                    stall,
  output logic                                    issue,
  output logic                                    halt
);

  logic uses_rs1, uses_rs2, is_mem, src_busy, may_go, ecall_seen;

  // source usage per kind
  assign uses_rs2 = (dec_op == rv_core_pkg::OP_ADD) || (dec_op == rv_core_pkg::OP_SUB) ||
                    (dec_op == rv_core_pkg::OP_AND) || (dec_op == rv_core_pkg::OP_OR)  ||
                    (dec_op == rv_core_pkg::OP_XOR) || (dec_op == rv_core_pkg::OP_SW);
  assign uses_rs1 = uses_rs2 || (dec_op == rv_core_pkg::OP_ADDI) ||
                    (dec_op == rv_core_pkg::OP_LW);
  assign is_mem   = (dec_op == rv_core_pkg::OP_LW) || (dec_op == rv_core_pkg::OP_SW);

  // no bypass, wait until the writer retires
  assign src_busy = (uses_rs1 && busy_regs[rs1]) || (uses_rs2 && busy_regs[rs2]);

  // nothing issues behind an ecall
  assign may_go = !cb_full && !src_busy && !(is_mem && d_busy) && !ecall_seen && !halt;

  assign stall = fd_valid && !may_go;
  // unknown words are consumed without an entry
  assign issue = fd_valid && may_go && (dec_op != rv_core_pkg::OP_ILLEGAL);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ecall_seen <= 1'b0;
      halt       <= 1'b0;
    end else begin
      if (issue && dec_op == rv_core_pkg::OP_ECALL)
        ecall_seen <= 1'b1;
      if (head_is_halt)
        halt <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
/*
 * memory arbiter
 * forwards one four-phase requester at a time onto the external bus,
 * data before fetch, grant held until the slave drops ack
 */
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
  input  wire logic                         CLK,
  input  wire logic                         nRST,
  input  wire logic                         if_req,
  input  wire logic [rv_core_pkg::XLEN-1:0] if_addr,
  output logic                              if_ack,
  output logic [rv_core_pkg::XLEN-1:0]      if_rdata,
  input  wire logic                         d_req,
  input  wire logic                         d_we,
  input  wire logic [rv_core_pkg::XLEN-1:0] d_addr,
  input  wire logic [rv_core_pkg::XLEN-1:0] d_wdata,
  output logic                              d_ack,
  output logic [rv_core_pkg::XLEN-1:0]      d_rdata,
  output logic                              bus_req,
  output logic                              bus_we,
  output logic [rv_core_pkg::XLEN-1:0]      bus_addr,
  output logic [rv_core_pkg::XLEN-1:0]      bus_wdata,
  input  wire logic [rv_core_pkg::XLEN-1:0] bus_rdata,
  input  wire logic                         bus_ack
);

  rv_core_pkg::bus_state_t state;
  logic                    grant_d, active;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= rv_core_pkg::BUS_IDLE;
      grant_d <= 1'b0;
    end else begin
      case (state)
        rv_core_pkg::BUS_IDLE: begin
          // previous ack must be gone first
          if (!bus_ack && (d_req || if_req)) begin
            grant_d <= d_req;
            state   <= rv_core_pkg::BUS_REQ;
          end
        end
        rv_core_pkg::BUS_REQ: begin
          if (bus_ack)
            state <= rv_core_pkg::BUS_RELEASE;
        end
        rv_core_pkg::BUS_RELEASE: begin
          if (!bus_ack)
            state <= rv_core_pkg::BUS_IDLE;
        end
        default: state <= rv_core_pkg::BUS_IDLE;
      endcase
    end
  end

  assign active = (state != rv_core_pkg::BUS_IDLE);

  // bus side follows the granted port
  assign bus_req   = (state == rv_core_pkg::BUS_REQ);
  assign bus_we    = grant_d && d_we;
  assign bus_addr  = grant_d ? d_addr : if_addr;
  assign bus_wdata = grant_d ? d_wdata : '0;

  // ack and read data only to the owner
  assign if_ack   = active && !grant_d && bus_ack;
  assign d_ack    = active && grant_d && bus_ack;
  assign if_rdata = grant_d ? '0 : bus_rdata;
  assign d_rdata  = grant_d ? bus_rdata : '0;

  // requesters hold their address for the whole grant
  a_addr_stable : assert property (@(posedge CLK) disable iff (!nRST)
    bus_req |=> !bus_req || $stable(bus_addr));

endmodule

`default_nettype wire

// File: src/reg_file.sv
/*
 * integer register file
 * 31 storage registers, x0 reads zero, two async reads, one write
 */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire logic                               CLK,
  input  wire logic                               nRST,
  input  wire logic [rv_core_pkg::REG_ADDR_W-1:0] rs1,
  input  wire logic [rv_core_pkg::REG_ADDR_W-1:0] rs2,
  output logic [rv_core_pkg::XLEN-1:0]            rd1,
  output logic [rv_core_pkg::XLEN-1:0]            rd2,
  input  wire logic                               wr_en,
  input  wire logic [rv_core_pkg::REG_ADDR_W-1:0] wr_addr,
  input  wire logic [rv_core_pkg::XLEN-1:0]       wr_data
);

  logic [rv_core_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 never stored
  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: src/rv_core.sv
/*
 * rv32i core top level
 * fetch, decode/execute, completion buffer, register file and hazard
 * control sharing one four-phase external bus through the arbiter
 */
`timescale 1ns/100ps
`default_nettype none

module rv_core (
  input  wire logic                         CLK,
  input  wire logic                         nRST,
  output logic                              bus_req,
  output logic                              bus_we,
  output logic [rv_core_pkg::XLEN-1:0]      bus_addr,
  output logic [rv_core_pkg::XLEN-1:0]      bus_wdata,
  input  wire logic [rv_core_pkg::XLEN-1:0] bus_rdata,
  input  wire logic                         bus_ack,
  output logic                              halt
);

  // fetch port and fetch to decode
  logic                                if_req, if_ack;
  logic [rv_core_pkg::XLEN-1:0]        if_addr, if_rdata;
  logic                                fd_valid;
  logic [rv_core_pkg::XLEN-1:0]        fd_instr;

  // hazard control
  logic                                stall, issue;
  rv_core_pkg::opcode_t                dec_op;

  // register file reads and retire writes
  logic [rv_core_pkg::REG_ADDR_W-1:0]  rs1, rs2, wr_addr;
  logic [rv_core_pkg::XLEN-1:0]        rd1, rd2, wr_data;
  logic                                wr_en;

  // completion buffer
  logic                                alloc, alloc_has_rd, alloc_halt;
  logic [rv_core_pkg::REG_ADDR_W-1:0]  alloc_rd;
  logic [rv_core_pkg::CB_IDX_W-1:0]    alloc_idx, cmp_idx;
  logic                                complete, cb_full, head_is_halt;
  logic [rv_core_pkg::XLEN-1:0]        cmp_data;
  logic [(1<<rv_core_pkg::REG_ADDR_W)-1:0] busy_regs;

  // data port
  logic                                d_req, d_we, d_ack, d_busy;
  logic [rv_core_pkg::XLEN-1:0]        d_addr, d_wdata, d_rdata;

  fetch_unit u_fetch (.*);

  decode_execute u_dec (.*);

  completion_buffer u_cb (.*);

  reg_file u_rf (.*);

  hazard_unit u_haz (.*);

  mem_arbiter u_arb (.*);

endmodule

`default_nettype wire

// File: src/rv_core_pkg.sv
/*
 * rv32i core package
 * shared widths, completion buffer size, reset vector and the
 * opcode and bus master state encodings
 */
`default_nettype none

package rv_core_pkg;

  // datapath and register index widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // completion buffer geometry
  localparam int CB_DEPTH = 4;
  localparam int CB_IDX_W = 2;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // supported instruction kinds after decode
  typedef enum logic [3:0] {
    OP_ADDI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_LUI,
    OP_LW,
    OP_SW,
    OP_ECALL,
    OP_ILLEGAL
  } opcode_t;

  // four-phase master phases
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_REQ,
    BUS_RELEASE
  } bus_state_t;

endpackage

`default_nettype wire
